/* run_sim.sh */
#!/usr/bin/env bash
# build and run the frequency meter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module freq_meter_tb --Mdir obj_dir -o freq_meter_sim > build.log 2>&1 \
	&& ./obj_dir/freq_meter_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log \
	&& { echo "simulation failed"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

/* sim/freq_meter_tb.sv */
// f_in is behavioral and each result may be one edge off the reference count
// the first strobe after an f_in change closes a mixed window and is skipped
`timescale 1ns/1ps
`default_nettype none

module freq_meter_tb;

	localparam int clk_period_ns = 40;
	localparam int window_cycles = 1 << freq_pkg::refcnt_width;
	localparam int window_ns = window_cycles * clk_period_ns;
	localparam int max_freq = (1 << freq_pkg::freq_width) - 1;
	localparam int n_tests = 6;
	// wait limits in sysclk cycles
	localparam int ack_limit = 4;
	localparam int strobe_limit = window_cycles + 16;

	logic sysclk;
	logic reset;
	logic f_in;
	logic g_in;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [wb_map_pkg::wb_data_width-1:0] wb_dat_w;
	logic [wb_map_pkg::wb_data_width-1:0] wb_dat_r;
	logic wb_ack;
	logic freq_strobe;
	logic glitch_catcher;

	// f_in generator controls
	bit f_run = 1'b0;
	int f_period = 100;
	// gate pattern in f_in edges
	int gate_on = 1;
	int gate_off = 0;
	int gate_phase;
	// main hands a check to the compare process
	int check_exp;
	int check_seq = 0;
	int done_seq = 0;
	int errors = 0;
	int checks = 0;

	freq_meter_top dut_i (
		.sysclk(sysclk),
		.reset(reset),
		.f_in(f_in),
		.g_in(g_in),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.freq_strobe(freq_strobe),
		.glitch_catcher(glitch_catcher)
	);

	initial begin
		sysclk = 1'b0;
		forever begin
			#(clk_period_ns / 2);
			sysclk = ~sysclk;
		end
	end

	// free-running f_in that parks low while stopped
	initial begin
		f_in = 1'b0;
		forever begin
			if (f_run) begin
				#(f_period / 2.0);
				f_in = ~f_in;
			end else begin
				f_in = 1'b0;
				wait (f_run);
			end
		end
	end

	// gate moves on falling f_in edges and stays on for gate_on edges then off for gate_off
	initial begin
		g_in = 1'b0;
		gate_phase = 0;
		forever begin
			@(negedge f_in);
			gate_phase = (gate_phase + 1) % (gate_on + gate_off);
			g_in = gate_phase < gate_on;
		end
	end

	// gated edges in one window with the gate phase taken to start at the window start
	function automatic int expected_count(input int period_ns, input int on_edges,
			input int off_edges);
		int total;
		int span;
		int rem;
		int count;
		total = window_ns / period_ns;
		span = on_edges + off_edges;
		rem = total % span;
		count = (total / span) * on_edges + ((rem < on_edges) ? rem : on_edges);
		if (count > max_freq) begin
			count = max_freq;
		end
		return count;
	endfunction

	task automatic check_equal(input string name, input int exp, input int act);
		checks++;
		assert (act == exp) else begin
			$display("Error at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_within_one(input string name, input int exp, input int act);
		checks++;
		assert ((act >= exp - 1) && (act <= exp + 1)) else begin
			$display("Error at %0d ns: %s expected %0d +-1, got %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	// one classic cycle with inputs moving on the falling edge
	task automatic wb_access(input logic [1:0] adr, input logic we, input logic [15:0] wdata,
			output logic [15:0] rdata, output bit ok);
		int waited;
		@(negedge sysclk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		waited = 0;
		ok = 1'b0;
		rdata = '0;
		while (!ok && waited < ack_limit) begin
			@(negedge sysclk);
			waited++;
			if (wb_ack) begin
				ok = 1'b1;
				rdata = wb_dat_r;
			end
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (!ok) begin
			$display("No wb_ack within %0d cycles for address %0d at %0d ns",
				ack_limit, adr, $time);
			errors++;
		end
	endtask

	task automatic wait_strobe(output bit ok);
		int waited;
		ok = 1'b0;
		waited = 0;
		while (!ok && waited < strobe_limit) begin
			@(negedge sysclk);
			waited++;
			ok = freq_strobe;
		end
		if (!ok) begin
			$display("No freq_strobe within %0d cycles at %0d ns", strobe_limit, $time);
			errors++;
		end
	endtask

	// let the f_in change settle and wait for the compare process
	task automatic run_check(input int exp);
		repeat (8) @(negedge sysclk);
		check_exp = exp;
		check_seq++;
		wait (done_seq == check_seq);
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		$display("test %0d (%s): %s", num, name, (errors == errs_before) ? "ok" : "failed");
	endtask

	// first strobe may close a mixed window so the second one is checked
	initial begin : compare
		logic [15:0] rd;
		bit ok;
		forever begin
			wait (check_seq != done_seq);
			wait_strobe(ok);
			if (ok) begin
				wait_strobe(ok);
			end
			if (ok) begin
				wb_access(wb_map_pkg::reg_freq, 1'b0, '0, rd, ok);
				if (ok) begin
					check_within_one("reg_freq", check_exp, int'(rd));
				end
			end
			done_seq = check_seq;
		end
	end

	initial begin : main
		logic [15:0] rd;
		bit ok;
		int p;
		int errs;
		void'($urandom(69725));
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (5) @(negedge sysclk);
		reset = 1'b0;

		errs = errors;
		check_equal("wb_ack", 0, int'(wb_ack));
		check_equal("freq_strobe", 0, int'(freq_strobe));
		check_equal("glitch_catcher", 0, int'(glitch_catcher));
		wb_access(wb_map_pkg::reg_freq, 1'b0, '0, rd, ok);
		check_equal("reg_freq", int'(freq_pkg::freq_init), int'(rd));
		wb_access(wb_map_pkg::reg_status, 1'b0, '0, rd, ok);
		check_equal("reg_status", 0, int'(rd));
		report_test(1, "reset values", errs);

		errs = errors;
		f_run = 1'b1;
		repeat (3) begin
			p = $urandom_range(300, 50);
			f_period = p;
			run_check(expected_count(p, 1, 0));
		end
		wb_access(wb_map_pkg::reg_glitch, 1'b0, '0, rd, ok);
		check_equal("reg_glitch", 0, int'(rd));
		report_test(2, "gate high, random f_in", errs);

		errs = errors;
		f_period = 100;
		gate_on = 0;
		gate_off = 1;
		run_check(expected_count(100, 0, 1));
		report_test(3, "gate low", errs);

		// 512 edges per window make a whole number of 16-edge gate periods
		errs = errors;
		f_period = 80;
		gate_on = 8;
		gate_off = 8;
		run_check(expected_count(80, 8, 8));
		report_test(4, "gate 8 on 8 off", errs);

		errs = errors;
		// clear the flag left set by earlier windows
		wb_access(wb_map_pkg::reg_status, 1'b0, '0, rd, ok);
		wait_strobe(ok);
		wb_access(wb_map_pkg::reg_status, 1'b0, '0, rd, ok);
		check_equal("reg_status[0]", 1, int'(rd[0]));
		wb_access(wb_map_pkg::reg_status, 1'b0, '0, rd, ok);
		check_equal("reg_status[0]", 0, int'(rd[0]));
		report_test(5, "new-result flag", errs);

		// 4 edges per sysclk cycle make every delta a glitch
		errs = errors;
		gate_on = 1;
		gate_off = 0;
		f_period = 10;
		run_check(expected_count(10, 1, 0));
		wb_access(wb_map_pkg::reg_glitch, 1'b0, '0, rd, ok);
		checks++;
		assert (rd != 0) else begin
			$display("reg_glitch stayed 0 after a window of fast f_in at %0d ns", $time);
			errors++;
		end
		f_run = 1'b0;
		repeat (10) @(negedge sysclk);
		wb_access(wb_map_pkg::reg_glitch, 1'b1, 16'hffff, rd, ok);
		wb_access(wb_map_pkg::reg_glitch, 1'b0, '0, rd, ok);
		check_equal("reg_glitch", 0, int'(rd));
		report_test(6, "fast f_in glitches", errs);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// six windows per test plus a margin
	initial begin : watchdog
		#(n_tests * 6 * window_ns + 20000);
		$display("Timeout, the tests did not finish at %0d ns", $time);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
verilog/freq_pkg.sv
verilog/wb_map_pkg.sv
verilog/gray_edge_counter.sv
verilog/cdc_delta.sv
verilog/gate_accumulator.sv
verilog/wb_freq_regs.sv
verilog/freq_meter_top.sv
sim/freq_meter_tb.sv

/* verilog/cdc_delta.sv */
// f_in may run up to about 7 edges per sysclk cycle before the delta aliases
// delta lags a code change by 4 sysclk cycles
`timescale 1ns/1ps
`default_nettype none

module cdc_delta (
	input logic sysclk,
	input logic reset,
	input logic [freq_pkg::gray_width-1:0] gray_count,
	output logic [freq_pkg::gray_width-1:0] delta,
	output logic glitch_pulse
);

	// two synchronizer flops, only safe because gray_count steps one bit
	logic [freq_pkg::gray_width-1:0] sync1;
	logic [freq_pkg::gray_width-1:0] sync2;
	// current and previous binary count
	logic [freq_pkg::gray_width-1:0] bin_cur;
	logic [freq_pkg::gray_width-1:0] bin_prev;
	// modular difference, kept at gray_width so wrap-around works
	logic [freq_pkg::gray_width-1:0] diff_next;

	// pipeline flushes from the counter during reset
	always_ff @(posedge sysclk) begin
		sync1 <= gray_count;
		sync2 <= sync1;
		bin_cur <= freq_pkg::gray_to_bin(sync2);
		bin_prev <= bin_cur;
	end

	assign diff_next = bin_cur - bin_prev;

	// edges seen this cycle, glitch flag lines up with it
	always_ff @(posedge sysclk) begin
		if (reset) begin
			delta <= '0;
			glitch_pulse <= 1'b0;
		end else begin
			delta <= diff_next;
			glitch_pulse <= diff_next > freq_pkg::glitch_thresh;
		end
	end

	// half the code range or more per cycle can't be told from a backward step,
	// so f_in is too fast or the counter made a non-gray jump
	a_step_in_range: assert property (
		@(posedge sysclk) disable iff (reset)
		diff_next < (1 << (freq_pkg::gray_width - 1))
	);

endmodule

`default_nettype wire

/* verilog/freq_meter_top.sv */
// single-channel gated frequency counter, g_in must be synchronous to f_in
// diff_stream_strobe stays internal, the stream is read over wishbone
`timescale 1ns/1ps
`default_nettype none

module freq_meter_top (
	input logic sysclk,
	input logic reset,
	input logic f_in,
	input logic g_in,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [1:0] wb_adr,
	input logic [wb_map_pkg::wb_data_width-1:0] wb_dat_w,
	output logic [wb_map_pkg::wb_data_width-1:0] wb_dat_r,
	output logic wb_ack,
	output logic freq_strobe,
	output logic glitch_catcher
);

	// f_in domain
	logic [freq_pkg::gray_width-1:0] gray_count;
	// sysclk domain
	logic [freq_pkg::gray_width-1:0] delta;
	logic glitch_pulse;
	logic [freq_pkg::freq_width-1:0] frequency;
	logic [15:0] diff_stream;

	gray_edge_counter gray_edge_counter_i (
		.f_in(f_in),
		.g_in(g_in),
		.gray_count(gray_count)
	);

	cdc_delta cdc_delta_i (
		.sysclk(sysclk),
		.reset(reset),
		.gray_count(gray_count),
		.delta(delta),
		.glitch_pulse(glitch_pulse)
	);

	gate_accumulator gate_accumulator_i (
		.sysclk(sysclk),
		.reset(reset),
		.delta(delta),
		.frequency(frequency),
		.freq_strobe(freq_strobe),
		.diff_stream(diff_stream),
		.diff_stream_strobe()
	);

	wb_freq_regs wb_freq_regs_i (
		.sysclk(sysclk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.frequency(frequency),
		.freq_strobe(freq_strobe),
		.diff_stream(diff_stream),
		.glitch_pulse(glitch_pulse),
		.glitch_catcher(glitch_catcher)
	);

endmodule

`default_nettype wire

/* verilog/freq_pkg.sv */
// measurement path constants, built for one configuration only
// gray_width must stay 4 so four deltas pack into the 16-bit stream
`default_nettype none

package freq_pkg;

	// gray counter width, also the width of the per-cycle delta
	localparam int unsigned gray_width = 4;
	// reference window is 2**refcnt_width sysclk cycles
	localparam int unsigned refcnt_width = 10;
	// result width, 1024 cycles * 15 edges max still fits
	localparam int unsigned freq_width = 16;
	// a delta above this counts as a glitch
	localparam int unsigned glitch_thresh = 2;
	// result value before the first window closes
	localparam logic [freq_width-1:0] freq_init = '0;

	// gray to binary, msb passes through and each lower bit folds in
	function automatic logic [gray_width-1:0] gray_to_bin(input logic [gray_width-1:0] g);
		logic [gray_width-1:0] b;
		b[gray_width-1] = g[gray_width-1];
		for (int i = gray_width - 2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	function automatic logic [gray_width-1:0] bin_to_gray(input logic [gray_width-1:0] b);
		return b ^ (b >> 1);
	endfunction

endpackage

`default_nettype wire

/* verilog/gate_accumulator.sv */
// window length is fixed at 2**refcnt_width sysclk cycles
// results not read before the next window are overwritten
`timescale 1ns/1ps
`default_nettype none

module gate_accumulator (
	input logic sysclk,
	input logic reset,
	input logic [freq_pkg::gray_width-1:0] delta,
	output logic [freq_pkg::freq_width-1:0] frequency,
	output logic freq_strobe,
	output logic [15:0] diff_stream,
	output logic diff_stream_strobe
);

	// free-running window counter and its registered carry
	logic [freq_pkg::refcnt_width-1:0] refcnt;
	logic ref_carry;
	logic [freq_pkg::freq_width-1:0] accum;
	logic [freq_pkg::freq_width-1:0] accum_next;
	// total of the last finished window and its strobe
	logic [freq_pkg::freq_width-1:0] result;
	logic result_strobe;

	// restart from zero on the carry so the carry-cycle delta opens the new window
	assign accum_next = (ref_carry ? '0 : accum)
		+ {{(freq_pkg::freq_width - freq_pkg::gray_width){1'b0}}, delta};

	always_ff @(posedge sysclk) begin
		if (reset) begin
			refcnt <= '0;
			ref_carry <= 1'b0;
			accum <= '0;
			result <= freq_pkg::freq_init;
			result_strobe <= 1'b0;
			frequency <= freq_pkg::freq_init;
			freq_strobe <= 1'b0;
		end else begin
			{ref_carry, refcnt} <= {1'b0, refcnt} + 1'b1;
			accum <= accum_next;
			// total of the finished window
			if (ref_carry) begin
				result <= accum;
			end
			result_strobe <= ref_carry;
			// frequency and its strobe leave together one cycle after the latch
			frequency <= result;
			freq_strobe <= result_strobe;
		end
	end

	// shift register of the last four deltas with the newest in the low nibble
	always_ff @(posedge sysclk) begin
		diff_stream <= {diff_stream[15-freq_pkg::gray_width:0], delta};
	end

	// every fourth cycle the stream holds four fresh deltas
	always_ff @(posedge sysclk) begin
		if (reset) begin
			diff_stream_strobe <= 1'b0;
		end else begin
			diff_stream_strobe <= refcnt[1:0] == 2'd3;
		end
	end

	// frequency only moves in the cycle that freq_strobe marks
	a_freq_with_strobe: assert property (
		@(posedge sysclk) disable iff (reset)
		!freq_strobe |-> $stable(frequency)
	);

endmodule

`default_nettype wire

/* verilog/gray_edge_counter.sv */
// runs on f_in alone, no reset; the count starts from its power-up value
// g_in must be synchronous to f_in
`timescale 1ns/1ps
`default_nettype none

module gray_edge_counter (
	input logic f_in,
	input logic g_in,
	output logic [freq_pkg::gray_width-1:0] gray_count
);

	// power-up value stands in for a reset in this domain
	logic [freq_pkg::gray_width-1:0] gray_q = '0;
	logic [freq_pkg::gray_width-1:0] gray_next;

	// step through binary so the next code differs in exactly one bit
	assign gray_next = freq_pkg::bin_to_gray(freq_pkg::gray_to_bin(gray_q) + 1'b1);

	always_ff @(posedge f_in) begin
		if (g_in) begin
			gray_q <= gray_next;
		end
	end

	assign gray_count = gray_q;

	// the sysclk side relies on single-bit steps to sample a coherent code
	a_one_bit_step: assert property (
		@(posedge f_in) g_in |=> $countones(gray_q ^ $past(gray_q)) == 1
	);

endmodule

`default_nettype wire

/* verilog/wb_freq_regs.sv */
// wishbone classic slave, every access takes two cycles and never stalls
// only a write to reg_glitch has an effect, other writes are acked and dropped
`timescale 1ns/1ps
`default_nettype none

module wb_freq_regs (
	input logic sysclk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [1:0] wb_adr,
	input logic [wb_map_pkg::wb_data_width-1:0] wb_dat_w,
	output logic [wb_map_pkg::wb_data_width-1:0] wb_dat_r,
	output logic wb_ack,
	input logic [freq_pkg::freq_width-1:0] frequency,
	input logic freq_strobe,
	input logic [15:0] diff_stream,
	input logic glitch_pulse,
	output logic glitch_catcher
);

	wb_map_pkg::wb_state_e state;
	wb_map_pkg::reg_addr_e addr;
	logic req;
	logic new_result;
	logic [wb_map_pkg::wb_data_width-1:0] glitch_count;

	assign addr = wb_map_pkg::reg_addr_e'(wb_adr);
	// stb is ignored in the ack state
	assign req = (state == wb_map_pkg::state_idle) && wb_cyc && wb_stb;
	assign wb_ack = state == wb_map_pkg::state_ack;

	// bus state, ack follows a request by one cycle
	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= wb_map_pkg::state_idle;
		end else if (req) begin
			state <= wb_map_pkg::state_ack;
		end else begin
			state <= wb_map_pkg::state_idle;
		end
	end

	// read data captured at the request, valid during ack
	always_ff @(posedge sysclk) begin
		if (req) begin
			case (addr)
				wb_map_pkg::reg_freq: wb_dat_r <= frequency;
				wb_map_pkg::reg_status: wb_dat_r <= {14'b0, glitch_catcher, new_result};
				wb_map_pkg::reg_stream: wb_dat_r <= diff_stream;
				default: wb_dat_r <= glitch_count;
			endcase
		end
	end

	// new-result flag, a strobe in the clearing cycle keeps it set
	always_ff @(posedge sysclk) begin
		if (reset) begin
			new_result <= 1'b0;
		end else if (freq_strobe) begin
			new_result <= 1'b1;
		end else if (req && !wb_we && addr == wb_map_pkg::reg_status) begin
			new_result <= 1'b0;
		end
	end

	// glitch count saturates, clearing takes priority over a count
	always_ff @(posedge sysclk) begin
		if (reset) begin
			glitch_count <= '0;
		end else if (req && wb_we && addr == wb_map_pkg::reg_glitch) begin
			glitch_count <= '0;
		end else if (glitch_pulse && glitch_count != '1) begin
			glitch_count <= glitch_count + 1'b1;
		end
	end

	// scope trigger toggles on every glitch
	always_ff @(posedge sysclk) begin
		if (reset) begin
			glitch_catcher <= 1'b0;
		end else if (glitch_pulse) begin
			glitch_catcher <= ~glitch_catcher;
		end
	end

	// ack only ever answers a request taken in idle
	a_ack_follows_req: assert property (
		@(posedge sysclk) disable iff (reset)
		wb_ack |-> $past(state == wb_map_pkg::state_idle && wb_cyc && wb_stb)
	);

endmodule

`default_nettype wire

/* verilog/wb_map_pkg.sv */
// register map and bus states of the wishbone classic port
`default_nettype none

package wb_map_pkg;

	// data bus width, equal to the result width
	localparam int unsigned wb_data_width = 16;

	// word addresses on the 2-bit wb_adr
	typedef enum logic [1:0] {
		// latest frequency result
		reg_freq = 2'd0,
		// bit 0 new result, bit 1 glitch pin level
		reg_status = 2'd1,
		// four packed deltas, newest in the low nibble
		reg_stream = 2'd2,
		// saturating glitch count, any write clears it
		reg_glitch = 2'd3
	} reg_addr_e;

	// slave answers every request in two cycles
	typedef enum logic {
		state_idle = 1'b0,
		state_ack = 1'b1
	} wb_state_e;

endpackage

`default_nettype wire
